/* hdl/plsv_settings.svh */
`ifndef PLSV_SETTINGS_SVH
`define PLSV_SETTINGS_SVH

// Local bus geometry.
`define PLSV_DATA_W 32
`define PLSV_ADDR_W 16

// Top address nibble of each region.
`define PLSV_REGION_CFG 4'h0
`define PLSV_REGION_DSP 4'h1
`define PLSV_REGION_BRAM 4'h2

`define PLSV_BRAM_AW 10
`define PLSV_READ_DELAY 3
`define PLSV_SAMPLE_W 16
`define PLSV_GAIN_FRAC 14

`define PLSV_ID 32'h504c_5356
`define PLSV_UNMAPPED_DATA 32'hdead_beef

`endif

/* hdl/plsv_pkg.sv */
`default_nettype none

`include "plsv_settings.svh"

package plsv_pkg;

	typedef logic [`PLSV_DATA_W-1:0] lb_data_t;
	typedef logic [`PLSV_ADDR_W-1:0] lb_addr_t;
	typedef logic [`PLSV_BRAM_AW-1:0] bram_addr_t;

	// Samples sit in the low half of a BRAM word.
	typedef logic signed [`PLSV_SAMPLE_W-1:0] sample_t;

	// Q1.14 gain.
	typedef logic signed [`PLSV_SAMPLE_W-1:0] gain_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DRAIN
	} player_state_t;

endpackage

`default_nettype wire

/* hdl/lb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module lb_decode (
	input wire pl_clk0,
	input wire rst,
	input wire wren,
	input wire plsv_pkg::lb_addr_t waddr,
	input wire plsv_pkg::lb_data_t wdata,
	input wire rden,
	input wire plsv_pkg::lb_addr_t raddr,
	input wire rdenlast,
	output logic cfg_wren,
	output logic cfg_rden,
	output logic dsp_wren,
	output logic dsp_rden,
	output logic bram_wren,
	output logic bram_rden,
	output plsv_pkg::lb_addr_t offset,
	output plsv_pkg::lb_data_t wdata_q,
	input wire cfg_rvalid,
	input wire plsv_pkg::lb_data_t cfg_rdata,
	input wire dsp_rvalid,
	input wire plsv_pkg::lb_data_t dsp_rdata,
	input wire bram_rvalid,
	input wire plsv_pkg::lb_data_t bram_rdata,
	output logic rvalid,
	output plsv_pkg::lb_data_t rdata,
	output logic rvalidlast
);
	logic [3:0] wregion;
	logic [3:0] rregion;
	logic unmapped_req;
	logic unmapped_q;
	logic unmapped_rvalid;
	logic pending;
	logic last_q;

	assign wregion = waddr[`PLSV_ADDR_W-1 -: 4];
	assign rregion = raddr[`PLSV_ADDR_W-1 -: 4];

	always_ff @(posedge pl_clk0) begin
		if (rst) begin
			cfg_wren <= 1'b0;
			dsp_wren <= 1'b0;
			bram_wren <= 1'b0;
			cfg_rden <= 1'b0;
			dsp_rden <= 1'b0;
			bram_rden <= 1'b0;
			unmapped_req <= 1'b0;
			unmapped_q <= 1'b0;
			pending <= 1'b0;
			last_q <= 1'b0;
		end else begin
			cfg_wren <= wren && wregion == `PLSV_REGION_CFG;
			dsp_wren <= wren && wregion == `PLSV_REGION_DSP;
			bram_wren <= wren && wregion == `PLSV_REGION_BRAM;
			cfg_rden <= rden && rregion == `PLSV_REGION_CFG;
			dsp_rden <= rden && rregion == `PLSV_REGION_DSP;
			bram_rden <= rden && rregion == `PLSV_REGION_BRAM;
			unmapped_req <= rden && rregion != `PLSV_REGION_CFG &&
				rregion != `PLSV_REGION_DSP && rregion != `PLSV_REGION_BRAM;
			// Gives unmapped reads the same latency as the register banks.
			unmapped_q <= unmapped_req;
			if (rden) begin
				pending <= 1'b1;
				last_q <= rdenlast;
			end else if (rvalid) begin
				pending <= 1'b0;
			end
		end
	end

	// A write owns the shared offset.
	always_ff @(posedge pl_clk0) begin
		offset <= wren ? waddr : raddr;
		wdata_q <= wdata;
	end

	assign unmapped_rvalid = unmapped_q;
	assign rvalid = cfg_rvalid || dsp_rvalid || bram_rvalid || unmapped_rvalid;
	assign rvalidlast = rvalid && last_q;

	always_comb begin
		if (cfg_rvalid) begin
			rdata = cfg_rdata;
		end else if (dsp_rvalid) begin
			rdata = dsp_rdata;
		end else if (bram_rvalid) begin
			rdata = bram_rdata;
		end else if (unmapped_rvalid) begin
			rdata = `PLSV_UNMAPPED_DATA;
		end else begin
			rdata = '0;
		end
	end

	a_single_read: assert property (@(posedge pl_clk0) disable iff (rst)
		rden |-> !pending);

	// Every bank answer belongs to the one outstanding read.
	a_rvalid_pending: assert property (@(posedge pl_clk0) disable iff (rst)
		rvalid |-> pending);

endmodule

`default_nettype wire

/* hdl/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module cfg_regs (
	input wire pl_clk0,
	input wire rst,
	input wire wren,
	input wire rden,
	input wire plsv_pkg::lb_addr_t offset,
	input wire plsv_pkg::lb_data_t wdata,
	output logic rvalid,
	output plsv_pkg::lb_data_t rdata,
	output logic enable,
	output logic loop,
	input wire playing,
	input wire [15:0] played_count
);
	import plsv_pkg::*;

	lb_data_t scratch;
	logic playing_q;

	always_ff @(posedge pl_clk0) begin
		if (rst) begin
			enable <= 1'b0;
			loop <= 1'b0;
			scratch <= '0;
			playing_q <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			playing_q <= playing;
			rvalid <= rden;
			if (wren && offset[1:0] == 2'd1) begin
				enable <= wdata[0];
				loop <= wdata[1];
			end else if (playing_q && !playing && !loop) begin
				// Run finished on its own.
				enable <= 1'b0;
			end
			if (wren && offset[1:0] == 2'd2) begin
				scratch <= wdata;
			end
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (rden) begin
			case (offset[1:0])
				2'd0: rdata <= `PLSV_ID;
				2'd1: rdata <= {30'd0, loop, enable};
				2'd2: rdata <= scratch;
				default: rdata <= {playing, 15'd0, played_count};
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/dsp_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module dsp_regs (
	input wire pl_clk0,
	input wire rst,
	input wire wren,
	input wire rden,
	input wire plsv_pkg::lb_addr_t offset,
	input wire plsv_pkg::lb_data_t wdata,
	output logic rvalid,
	output plsv_pkg::lb_data_t rdata,
	output plsv_pkg::gain_t gain,
	output plsv_pkg::sample_t offset_val,
	output plsv_pkg::bram_addr_t start,
	output logic [`PLSV_BRAM_AW:0] length
);
	import plsv_pkg::*;

	localparam gain_t GAIN_ONE = gain_t'(1 << `PLSV_GAIN_FRAC);
	localparam logic [`PLSV_BRAM_AW:0] LEN_MAX = 1 << `PLSV_BRAM_AW;
	localparam logic [`PLSV_BRAM_AW:0] LEN_MIN = 1;

	logic [`PLSV_BRAM_AW:0] len_wr;

	// Length stays within 1 to the memory depth.
	always_comb begin
		if (wdata == '0) begin
			len_wr = LEN_MIN;
		end else if (wdata > lb_data_t'(LEN_MAX)) begin
			len_wr = LEN_MAX;
		end else begin
			len_wr = wdata[`PLSV_BRAM_AW:0];
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (rst) begin
			gain <= GAIN_ONE;
			offset_val <= '0;
			start <= '0;
			length <= LEN_MAX;
			rvalid <= 1'b0;
		end else begin
			rvalid <= rden;
			if (wren) begin
				case (offset[1:0])
					2'd0: gain <= wdata[`PLSV_SAMPLE_W-1:0];
					2'd1: offset_val <= wdata[`PLSV_SAMPLE_W-1:0];
					2'd2: start <= wdata[`PLSV_BRAM_AW-1:0];
					default: length <= len_wr;
				endcase
			end
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (rden) begin
			case (offset[1:0])
				2'd0: rdata <= {{(`PLSV_DATA_W-`PLSV_SAMPLE_W){gain[`PLSV_SAMPLE_W-1]}}, gain};
				2'd1: rdata <= {{(`PLSV_DATA_W-`PLSV_SAMPLE_W){offset_val[`PLSV_SAMPLE_W-1]}},
					offset_val};
				2'd2: rdata <= lb_data_t'(start);
				default: rdata <= lb_data_t'(length);
			endcase
		end
	end

	a_length_nonzero: assert property (@(posedge pl_clk0) disable iff (rst)
		length != '0);

endmodule

`default_nettype wire

/* hdl/bram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module bram_ctrl (
	input wire pl_clk0,
	input wire wren,
	input wire rden,
	input wire plsv_pkg::lb_addr_t offset,
	input wire plsv_pkg::lb_data_t wdata,
	output logic rvalid,
	output plsv_pkg::lb_data_t rdata,
	input wire play_rden,
	input wire plsv_pkg::bram_addr_t play_addr,
	output logic play_rvalid,
	output plsv_pkg::sample_t play_rdata
);
	import plsv_pkg::*;

	localparam int DEPTH = 1 << `PLSV_BRAM_AW;
	localparam int DELAY = `PLSV_READ_DELAY;
	localparam int PORTS = 2;

	lb_data_t mem [DEPTH];
	bram_addr_t port_addr [PORTS];
	logic port_rden [PORTS];
	logic vld_pipe [PORTS][DELAY];
	lb_data_t dat_pipe [PORTS][DELAY];

	// Port 0 is the bus, port 1 the player.
	assign port_addr[0] = offset[`PLSV_BRAM_AW-1:0];
	assign port_addr[1] = play_addr;
	assign port_rden[0] = rden;
	assign port_rden[1] = play_rden;

	always_ff @(posedge pl_clk0) begin
		if (wren) begin
			mem[port_addr[0]] <= wdata;
		end
		for (int p = 0; p < PORTS; p++) begin
			vld_pipe[p][0] <= port_rden[p];
			dat_pipe[p][0] <= mem[port_addr[p]];
			for (int s = 1; s < DELAY; s++) begin
				vld_pipe[p][s] <= vld_pipe[p][s-1];
				dat_pipe[p][s] <= dat_pipe[p][s-1];
			end
		end
	end

	assign rvalid = vld_pipe[0][DELAY-1];
	assign rdata = dat_pipe[0][DELAY-1];
	assign play_rvalid = vld_pipe[1][DELAY-1];
	assign play_rdata = dat_pipe[1][DELAY-1][`PLSV_SAMPLE_W-1:0];

endmodule

`default_nettype wire

/* hdl/wave_player.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module wave_player (
	input wire pl_clk0,
	input wire rst,
	input wire enable,
	input wire loop,
	input wire plsv_pkg::gain_t gain,
	input wire plsv_pkg::sample_t offset_val,
	input wire plsv_pkg::bram_addr_t start,
	input wire [`PLSV_BRAM_AW:0] length,
	output logic play_rden,
	output plsv_pkg::bram_addr_t play_addr,
	input wire play_rvalid,
	input wire plsv_pkg::sample_t play_rdata,
	output logic sample_valid,
	input wire sample_ready,
	output plsv_pkg::sample_t sample_data,
	output logic playing,
	output logic [15:0] played_count
);
	import plsv_pkg::*;

	localparam int BUF_DEPTH = 4;
	localparam int SUM_W = 2 * `PLSV_SAMPLE_W + 1 - `PLSV_GAIN_FRAC;
	localparam logic signed [SUM_W-1:0] SAT_MAX = 32767;
	localparam logic signed [SUM_W-1:0] SAT_MIN = -32768;

	player_state_t state;
	logic armed;
	logic [`PLSV_BRAM_AW:0] remain;
	logic [2:0] inflight;
	logic [2:0] count;
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	sample_t fifo [BUF_DEPTH];
	logic has_credit;
	logic pop;
	logic signed [2*`PLSV_SAMPLE_W-1:0] product;
	logic signed [SUM_W-2:0] scaled;
	logic signed [SUM_W-1:0] summed;
	sample_t result;

	// Buffer slots already spoken for by reads in flight count as used.
	assign has_credit = ({1'b0, count} + {1'b0, inflight}) < 4'(BUF_DEPTH);
	assign play_rden = state == ST_RUN && enable && has_credit;
	assign sample_valid = count != 3'd0;
	assign sample_data = fifo[rd_ptr];
	assign pop = sample_valid && sample_ready;
	assign playing = state != ST_IDLE;

	assign product = play_rdata * gain;
	assign scaled = product[2*`PLSV_SAMPLE_W-1:`PLSV_GAIN_FRAC];
	assign summed = scaled + offset_val;

	always_comb begin
		if (summed > SAT_MAX) begin
			result = SAT_MAX[`PLSV_SAMPLE_W-1:0];
		end else if (summed < SAT_MIN) begin
			result = SAT_MIN[`PLSV_SAMPLE_W-1:0];
		end else begin
			result = summed[`PLSV_SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (rst) begin
			state <= ST_IDLE;
			armed <= 1'b1;
			remain <= '0;
			play_addr <= '0;
			inflight <= '0;
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			played_count <= '0;
		end else begin
			// A finished run waits for enable to go low before it may start again.
			if (!enable) begin
				armed <= 1'b1;
			end
			inflight <= inflight + 3'(play_rden) - 3'(play_rvalid);
			count <= count + 3'(play_rvalid) - 3'(pop);
			if (play_rvalid) begin
				wr_ptr <= wr_ptr + 2'd1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 2'd1;
				played_count <= played_count + 16'd1;
			end
			case (state)
				ST_IDLE: begin
					if (enable && armed) begin
						state <= ST_RUN;
						armed <= 1'b0;
						play_addr <= start;
						remain <= length;
						played_count <= '0;
					end
				end
				ST_RUN: begin
					if (!enable) begin
						state <= ST_DRAIN;
					end else if (play_rden) begin
						if (remain == 1) begin
							if (loop) begin
								play_addr <= start;
								remain <= length;
							end else begin
								state <= ST_DRAIN;
							end
						end else begin
							play_addr <= play_addr + 1'b1;
							remain <= remain - 1'b1;
						end
					end
				end
				ST_DRAIN: begin
					if (inflight == '0 && count == '0) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge pl_clk0) begin
		if (play_rvalid) begin
			fifo[wr_ptr] <= result;
		end
	end

	// Memory latency and the credit count must agree.
	a_no_overflow: assert property (@(posedge pl_clk0) disable iff (rst)
		play_rvalid |-> (count < 3'(BUF_DEPTH) || pop));

endmodule

`default_nettype wire

/* hdl/plsv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module plsv (
	input wire pl_clk0,
	input wire rst,
	input wire wren,
	input wire plsv_pkg::lb_addr_t waddr,
	input wire plsv_pkg::lb_data_t wdata,
	input wire rden,
	input wire plsv_pkg::lb_addr_t raddr,
	input wire rdenlast,
	output logic rvalid,
	output plsv_pkg::lb_data_t rdata,
	output logic rvalidlast,
	output logic sample_valid,
	input wire sample_ready,
	output plsv_pkg::sample_t sample_data
);
	import plsv_pkg::*;

	logic cfg_wren;
	logic cfg_rden;
	logic dsp_wren;
	logic dsp_rden;
	logic bram_wren;
	logic bram_rden;
	lb_addr_t offset;
	lb_data_t wdata_q;
	logic cfg_rvalid;
	lb_data_t cfg_rdata;
	logic dsp_rvalid;
	lb_data_t dsp_rdata;
	logic bram_rvalid;
	lb_data_t bram_rdata;
	logic enable;
	logic loop;
	logic playing;
	logic [15:0] played_count;
	gain_t gain;
	sample_t offset_val;
	bram_addr_t start;
	logic [`PLSV_BRAM_AW:0] length;
	logic play_rden;
	bram_addr_t play_addr;
	logic play_rvalid;
	sample_t play_rdata;

	lb_decode lb_decode_i (
		.pl_clk0(pl_clk0), .rst(rst),
		.wren(wren), .waddr(waddr), .wdata(wdata),
		.rden(rden), .raddr(raddr), .rdenlast(rdenlast),
		.cfg_wren(cfg_wren), .cfg_rden(cfg_rden),
		.dsp_wren(dsp_wren), .dsp_rden(dsp_rden),
		.bram_wren(bram_wren), .bram_rden(bram_rden),
		.offset(offset), .wdata_q(wdata_q),
		.cfg_rvalid(cfg_rvalid), .cfg_rdata(cfg_rdata),
		.dsp_rvalid(dsp_rvalid), .dsp_rdata(dsp_rdata),
		.bram_rvalid(bram_rvalid), .bram_rdata(bram_rdata),
		.rvalid(rvalid), .rdata(rdata), .rvalidlast(rvalidlast)
	);

	cfg_regs cfg_regs_i (
		.pl_clk0(pl_clk0), .rst(rst),
		.wren(cfg_wren), .rden(cfg_rden), .offset(offset), .wdata(wdata_q),
		.rvalid(cfg_rvalid), .rdata(cfg_rdata),
		.enable(enable), .loop(loop), .playing(playing), .played_count(played_count)
	);

	dsp_regs dsp_regs_i (
		.pl_clk0(pl_clk0), .rst(rst),
		.wren(dsp_wren), .rden(dsp_rden), .offset(offset), .wdata(wdata_q),
		.rvalid(dsp_rvalid), .rdata(dsp_rdata),
		.gain(gain), .offset_val(offset_val), .start(start), .length(length)
	);

	bram_ctrl bram_ctrl_i (
		.pl_clk0(pl_clk0),
		.wren(bram_wren), .rden(bram_rden), .offset(offset), .wdata(wdata_q),
		.rvalid(bram_rvalid), .rdata(bram_rdata),
		.play_rden(play_rden), .play_addr(play_addr),
		.play_rvalid(play_rvalid), .play_rdata(play_rdata)
	);

	wave_player wave_player_i (
		.pl_clk0(pl_clk0), .rst(rst),
		.enable(enable), .loop(loop), .gain(gain), .offset_val(offset_val),
		.start(start), .length(length),
		.play_rden(play_rden), .play_addr(play_addr),
		.play_rvalid(play_rvalid), .play_rdata(play_rdata),
		.sample_valid(sample_valid), .sample_ready(sample_ready),
		.sample_data(sample_data),
		.playing(playing), .played_count(played_count)
	);

endmodule

`default_nettype wire

/* dv/tb_plsv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plsv_settings.svh"

module tb_plsv;
	import plsv_pkg::*;

	// Six short tests need a few thousand cycles, so this leaves a wide margin.
	localparam int TIMEOUT_CYCLES = 20000;
	localparam lb_addr_t CFG_ID = {`PLSV_REGION_CFG, 12'd0};
	localparam lb_addr_t CFG_CTRL = {`PLSV_REGION_CFG, 12'd1};
	localparam lb_addr_t CFG_SCRATCH = {`PLSV_REGION_CFG, 12'd2};
	localparam lb_addr_t CFG_STATUS = {`PLSV_REGION_CFG, 12'd3};
	localparam lb_addr_t DSP_BASE = {`PLSV_REGION_DSP, 12'd0};
	localparam lb_addr_t UNMAPPED_ADDR = {4'h5, 12'h010};

	logic pl_clk0;
	logic rst;
	logic wren;
	lb_addr_t waddr;
	lb_data_t wdata;
	logic rden;
	lb_addr_t raddr;
	logic rdenlast;
	logic rvalid;
	lb_data_t rdata;
	logic rvalidlast;
	logic sample_valid;
	logic sample_ready;
	sample_t sample_data;

	int errors;
	int tests_run;
	int cycles;
	logic [31:0] bus_lfsr;
	logic [31:0] ready_lfsr;
	logic ready_random;
	logic [15:0] got_q [$];
	logic prev_stall;
	logic [15:0] prev_data;
	sample_t wave [8];
	lb_data_t model [1 << `PLSV_BRAM_AW];

	plsv plsv_i (
		.pl_clk0(pl_clk0), .rst(rst),
		.wren(wren), .waddr(waddr), .wdata(wdata),
		.rden(rden), .raddr(raddr), .rdenlast(rdenlast),
		.rvalid(rvalid), .rdata(rdata), .rvalidlast(rvalidlast),
		.sample_valid(sample_valid), .sample_ready(sample_ready),
		.sample_data(sample_data)
	);

	always #4 pl_clk0 = ~pl_clk0;

	// Galois form with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < n; b++) begin
			value = {value[30:0], bus_lfsr[0]};
			bus_lfsr = lfsr_next(bus_lfsr);
		end
		return value;
	endfunction

	// Multiply, shift right by the fraction bits, add the offset, saturate.
	function automatic logic [15:0] scale_sample(input logic signed [15:0] s,
		input logic signed [15:0] g, input logic signed [15:0] o);
		int prod;
		int sum;
		prod = int'(s) * int'(g);
		sum = (prod >>> `PLSV_GAIN_FRAC) + int'(o);
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		return sum[15:0];
	endfunction

	function automatic lb_addr_t bram_word(input int a);
		return {`PLSV_REGION_BRAM, 2'b00, a[`PLSV_BRAM_AW-1:0]};
	endfunction

	task automatic log_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	endtask

	task automatic count_failure(input string what);
		errors++;
		$display("Failure: %s at %0t", what, $time);
	endtask

	task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
		@(posedge pl_clk0);
		#1;
		wren = 1'b1;
		waddr = addr;
		wdata = data;
		@(posedge pl_clk0);
		#1;
		wren = 1'b0;
	endtask

	task automatic bus_read(input lb_addr_t addr, input logic last,
		output lb_data_t data, output logic data_last);
		int waits;
		int latency;
		waits = 0;
		// The BRAM answers after its read delay plus the decoder stage.
		if (addr[`PLSV_ADDR_W-1 -: 4] == `PLSV_REGION_BRAM) begin
			latency = 1 + `PLSV_READ_DELAY;
		end else begin
			latency = 2;
		end
		@(posedge pl_clk0);
		#1;
		rden = 1'b1;
		raddr = addr;
		rdenlast = last;
		@(posedge pl_clk0);
		#1;
		rden = 1'b0;
		rdenlast = 1'b0;
		while (!rvalid) begin
			@(posedge pl_clk0);
			#1;
			waits++;
		end
		if (waits + 1 != latency) begin
			log_mismatch("rvalid latency", 32'(waits + 1), 32'(latency));
		end
		data = rdata;
		data_last = rvalidlast;
	endtask

	task automatic load_wave(input int first, input int n);
		for (int i = 0; i < n; i++) begin
			bus_write(bram_word(first + i), {~wave[i], wave[i]});
		end
	endtask

	task automatic set_dsp(input logic [15:0] gain, input logic [15:0] off,
		input int first, input int len);
		bus_write(DSP_BASE, {16'h0000, gain});
		bus_write(DSP_BASE + 16'd1, {16'h0000, off});
		bus_write(DSP_BASE + 16'd2, 32'(first));
		bus_write(DSP_BASE + 16'd3, 32'(len));
	endtask

	task automatic collect_samples(input int n);
		while (got_q.size() < n) begin
			@(posedge pl_clk0);
		end
	endtask

	task automatic poll_until_idle(output lb_data_t status);
		logic last;
		do begin
			bus_read(CFG_STATUS, 1'b0, status, last);
		end while (status[31]);
	endtask

	task automatic id_and_scratch();
		lb_data_t data;
		logic last;
		bus_read(CFG_ID, 1'b0, data, last);
		if (data != `PLSV_ID) begin
			log_mismatch("rdata", data, `PLSV_ID);
		end
		bus_write(CFG_SCRATCH, 32'ha5c3_1e07);
		bus_read(CFG_SCRATCH, 1'b0, data, last);
		if (data != 32'ha5c3_1e07) begin
			log_mismatch("rdata", data, 32'ha5c3_1e07);
		end
		bus_write(CFG_ID, 32'h1234_5678);
		bus_read(CFG_ID, 1'b0, data, last);
		if (data != `PLSV_ID) begin
			log_mismatch("rdata", data, `PLSV_ID);
		end
		tests_run++;
	endtask

	task automatic unmapped_and_last();
		lb_data_t data;
		logic last;
		bus_read(UNMAPPED_ADDR, 1'b1, data, last);
		if (data != `PLSV_UNMAPPED_DATA) begin
			log_mismatch("rdata", data, `PLSV_UNMAPPED_DATA);
		end
		if (last != 1'b1) begin
			log_mismatch("rvalidlast", 32'(last), 32'h1);
		end
		bus_read(CFG_SCRATCH, 1'b0, data, last);
		if (last != 1'b0) begin
			log_mismatch("rvalidlast", 32'(last), 32'h0);
		end
		tests_run++;
	endtask

	task automatic bram_random_rw();
		logic [`PLSV_BRAM_AW-1:0] addrs [8];
		lb_data_t data;
		logic last;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = `PLSV_BRAM_AW'(take_bits(`PLSV_BRAM_AW));
			model[addrs[i]] = take_bits(32);
			bus_write(bram_word(int'(addrs[i])), model[addrs[i]]);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(bram_word(int'(addrs[i])), 1'b0, data, last);
			if (data != model[addrs[i]]) begin
				log_mismatch("rdata", data, model[addrs[i]]);
			end
		end
		tests_run++;
	endtask

	task automatic single_run();
		lb_data_t status;
		lb_data_t data;
		logic last;
		for (int i = 0; i < 8; i++) begin
			wave[i] = 16'(16'h0111 * (i + 1) - 16'h0400);
		end
		load_wave(5, 8);
		set_dsp(16'(1 << `PLSV_GAIN_FRAC), 16'd0, 5, 8);
		ready_random = 1'b0;
		got_q.delete();
		bus_write(CFG_CTRL, 32'h1);
		collect_samples(8);
		poll_until_idle(status);
		if (status[15:0] != 16'd8) begin
			log_mismatch("played_count", 32'(status[15:0]), 32'd8);
		end
		if (got_q.size() != 8) begin
			count_failure("single run gave the wrong number of samples");
		end
		for (int i = 0; i < 8 && i < got_q.size(); i++) begin
			if (got_q[i] != wave[i]) begin
				log_mismatch("sample_data", 32'(got_q[i]), 32'(wave[i]));
			end
		end
		bus_read(CFG_CTRL, 1'b0, data, last);
		if (data[0] != 1'b0) begin
			log_mismatch("enable", 32'(data[0]), 32'h0);
		end
		tests_run++;
	endtask

	task automatic scaled_run();
		lb_data_t status;
		logic [15:0] exp;
		wave[0] = 16'sd30000;
		wave[1] = -16'sd30000;
		wave[2] = 16'sd100;
		wave[3] = -16'sd5000;
		wave[4] = 16'sd0;
		wave[5] = 16'sd12345;
		wave[6] = -16'sd18000;
		wave[7] = 16'sd7;
		load_wave(100, 8);
		// Gain 1.75 drives the first two samples into both rails.
		set_dsp(16'd28672, 16'd1000, 100, 8);
		ready_random = 1'b1;
		got_q.delete();
		bus_write(CFG_CTRL, 32'h1);
		collect_samples(8);
		poll_until_idle(status);
		if (got_q.size() != 8) begin
			count_failure("scaled run gave the wrong number of samples");
		end
		for (int i = 0; i < 8 && i < got_q.size(); i++) begin
			exp = scale_sample(wave[i], 16'sd28672, 16'sd1000);
			if (got_q[i] != exp) begin
				log_mismatch("sample_data", 32'(got_q[i]), 32'(exp));
			end
		end
		tests_run++;
	endtask

	task automatic looped_run();
		lb_data_t status;
		logic [15:0] exp;
		for (int i = 0; i < 5; i++) begin
			wave[i] = 16'(16'h1000 + 16'h0203 * i);
		end
		load_wave(200, 5);
		set_dsp(16'(1 << `PLSV_GAIN_FRAC), 16'd0, 200, 5);
		ready_random = 1'b1;
		got_q.delete();
		bus_write(CFG_CTRL, 32'h3);
		collect_samples(23);
		bus_write(CFG_CTRL, 32'h0);
		poll_until_idle(status);
		if (32'(status[15:0]) != got_q.size()) begin
			log_mismatch("played_count", 32'(status[15:0]), got_q.size());
		end
		for (int i = 0; i < got_q.size(); i++) begin
			exp = scale_sample(wave[i % 5], 16'(1 << `PLSV_GAIN_FRAC), 16'sd0);
			if (got_q[i] != exp) begin
				log_mismatch("sample_data", 32'(got_q[i]), 32'(exp));
			end
		end
		ready_random = 1'b0;
		tests_run++;
	endtask

	always @(posedge pl_clk0) begin
		#1;
		if (ready_random) begin
			sample_ready = ready_lfsr[0];
			ready_lfsr = lfsr_next(ready_lfsr);
		end else begin
			sample_ready = 1'b1;
		end
	end

	// Outputs and sample_ready are all settled at the falling edge.
	always @(negedge pl_clk0) begin
		if (!rst) begin
			if (prev_stall && !sample_valid) begin
				count_failure("sample_valid dropped while sample_ready was low");
			end else if (prev_stall && sample_data != prev_data) begin
				log_mismatch("sample_data", 32'(sample_data), 32'(prev_data));
			end
			if (sample_valid && sample_ready) begin
				got_q.push_back(sample_data);
			end
			prev_stall = sample_valid && !sample_ready;
			prev_data = sample_data;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge pl_clk0);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		pl_clk0 = 1'b0;
		rst = 1'b1;
		wren = 1'b0;
		waddr = '0;
		wdata = '0;
		rden = 1'b0;
		raddr = '0;
		rdenlast = 1'b0;
		sample_ready = 1'b1;
		ready_random = 1'b0;
		bus_lfsr = 32'd71993;
		ready_lfsr = 32'd71993;
		errors = 0;
		tests_run = 0;
		prev_stall = 1'b0;
		prev_data = '0;
		repeat (10) @(posedge pl_clk0);
		#1;
		rst = 1'b0;
		id_and_scratch();
		unmapped_and_last();
		bram_random_rw();
		single_run();
		scaled_run();
		looped_run();
		$display("Summary: %0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/plsv_pkg.sv
hdl/lb_decode.sv
hdl/cfg_regs.sv
hdl/dsp_regs.sv
hdl/bram_ctrl.sv
hdl/wave_player.sv
hdl/plsv.sv
dv/tb_plsv.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_plsv
FILELIST = compile.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
